/* source/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_num_t;

    // low bit of each instruction field
    localparam int op_pos     = 26;
    localparam int rs_pos     = 21;
    localparam int rt_pos     = 16;
    localparam int rd_pos     = 11;
    localparam int sa_pos     = 6;
    localparam int fn_pos     = 0;
    localparam int imm_pos    = 0;
    localparam int target_pos = 0;

    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_j       = 6'b000010;
    localparam logic [5:0] op_jal     = 6'b000011;
    localparam logic [5:0] op_beq     = 6'b000100;
    localparam logic [5:0] op_bne     = 6'b000101;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_slti    = 6'b001010;
    localparam logic [5:0] op_sltiu   = 6'b001011;
    localparam logic [5:0] op_andi    = 6'b001100;
    localparam logic [5:0] op_ori     = 6'b001101;
    localparam logic [5:0] op_xori    = 6'b001110;
    localparam logic [5:0] op_lui     = 6'b001111;
    localparam logic [5:0] op_lb      = 6'b100000;
    localparam logic [5:0] op_lh      = 6'b100001;
    localparam logic [5:0] op_lw      = 6'b100011;
    localparam logic [5:0] op_lbu     = 6'b100100;
    localparam logic [5:0] op_lhu     = 6'b100101;
    localparam logic [5:0] op_sb      = 6'b101000;
    localparam logic [5:0] op_sh      = 6'b101001;
    localparam logic [5:0] op_sw      = 6'b101011;

    // funct field of op_special
    localparam logic [5:0] fn_sll  = 6'b000000;
    localparam logic [5:0] fn_srl  = 6'b000010;
    localparam logic [5:0] fn_sra  = 6'b000011;
    localparam logic [5:0] fn_jr   = 6'b001000;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_subu = 6'b100011;
    localparam logic [5:0] fn_and  = 6'b100100;
    localparam logic [5:0] fn_or   = 6'b100101;
    localparam logic [5:0] fn_xor  = 6'b100110;
    localparam logic [5:0] fn_nor  = 6'b100111;
    localparam logic [5:0] fn_slt  = 6'b101010;
    localparam logic [5:0] fn_sltu = 6'b101011;

    // link register written by jal
    localparam reg_num_t reg_ra = 5'd31;

endpackage

/* source/cpu_pipe_pkg.sv */
package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

    typedef enum logic [2:0] {
        mem_none,
        mem_byte,
        mem_byte_u,
        mem_half,
        mem_half_u,
        mem_word
    } mem_access_t;

    // operand sources of the alu
    typedef enum logic [1:0] {
        src_a_rs,
        src_a_shamt,
        src_a_pc
    } src_a_t;

    typedef enum logic [1:0] {
        src_b_rt,
        src_b_imm,
        src_b_eight
    } src_b_t;

    typedef struct packed {
        word_t       pc;
        word_t       rs_value;
        word_t       rt_value;
        word_t       imm;
        logic [4:0]  shamt;
        alu_op_t     alu_op;
        src_a_t      src_a;
        src_b_t      src_b;
        mem_access_t mem_access;
        logic        store;
        logic        reg_write;
        reg_num_t    dest;
        logic        load;
    } id_ex_t;

    typedef struct packed {
        word_t       pc;
        word_t       result;
        logic [1:0]  offset;
        mem_access_t mem_access;
        logic        reg_write;
        reg_num_t    dest;
        logic        load;
    } ex_mem_t;

    typedef struct packed {
        word_t    pc;
        logic     reg_write;
        reg_num_t dest;
        word_t    wdata;
    } mem_wb_t;

endpackage

/* source/pipe_stage_reg.sv */
`timescale 1ns/1ps

module pipe_stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     valid_in,
    input  logic     allow_out,
    input  payload_t in,
    output logic     allow_in,
    output logic     valid_out,
    output logic     valid,
    output payload_t out
);

    // item leaves only when not held by this stage
    assign valid_out = valid & ~stall;
    assign allow_in  = ~valid | (valid_out & allow_out);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (allow_in) begin
            valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (allow_in && valid_in) begin
            out <= in;
        end
    end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit import cpu_isa_pkg::*; #(
    parameter word_t reset_pc = 32'hbfc00000
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  allow_in,
    input  logic  redirect,
    input  word_t redirect_pc,
    output word_t pc,
    output logic  start,
    output word_t fetch_addr
);

    // sram returns the word one cycle later, so the address leads pc by a cycle
    always_comb begin
        if (!allow_in) begin
            fetch_addr = pc;
        end else if (redirect) begin
            fetch_addr = redirect_pc;
        end else begin
            fetch_addr = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc    <= reset_pc - 32'd4;
            start <= 1'b0;
        end else begin
            pc    <= fetch_addr;
            start <= 1'b1;
        end
    end

endmodule

/* source/decode_control.sv */
`timescale 1ns/1ps

module decode_control import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
    input  word_t    instr,
    input  word_t    pc,
    input  word_t    if_pc,
    input  logic     valid,
    input  word_t    rs_value,
    input  word_t    rt_value,
    output reg_num_t rs,
    output reg_num_t rt,
    output logic     redirect,
    output word_t    redirect_pc,
    output id_ex_t   payload
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_num_t   rd;
    word_t      imm_sext;
    word_t      imm_zext;
    word_t      branch_target;
    word_t      jump_target;

    function automatic mem_access_t access_of(logic [5:0] op);
        case (op)
            op_lb, op_sb: return mem_byte;
            op_lbu:       return mem_byte_u;
            op_lh, op_sh: return mem_half;
            op_lhu:       return mem_half_u;
            op_lw, op_sw: return mem_word;
            default:      return mem_none;
        endcase
    endfunction

    assign opcode   = instr[op_pos +: 6];
    assign funct    = instr[fn_pos +: 6];
    assign rs       = instr[rs_pos +: 5];
    assign rt       = instr[rt_pos +: 5];
    assign rd       = instr[rd_pos +: 5];
    assign imm_sext = {{16{instr[imm_pos + 15]}}, instr[imm_pos +: 16]};
    assign imm_zext = {16'd0, instr[imm_pos +: 16]};

    // targets are relative to the delay slot, which sits in IF
    assign branch_target = if_pc + {imm_sext[29:0], 2'b00};
    assign jump_target   = {if_pc[31:28], instr[target_pos +: 26], 2'b00};

    always_comb begin
        payload            = '0;
        payload.pc         = pc;
        payload.rs_value   = rs_value;
        payload.rt_value   = rt_value;
        payload.imm        = imm_sext;
        payload.shamt      = instr[sa_pos +: 5];
        payload.alu_op     = alu_add;
        payload.src_a      = src_a_rs;
        payload.src_b      = src_b_imm;
        payload.mem_access = access_of(opcode);
        payload.dest       = rt;
        redirect           = 1'b0;
        redirect_pc        = branch_target;

        case (opcode)
            op_special: begin
                payload.src_b     = src_b_rt;
                payload.dest      = rd;
                payload.reg_write = 1'b1;
                case (funct)
                    fn_addu: payload.alu_op = alu_add;
                    fn_subu: payload.alu_op = alu_sub;
                    fn_and:  payload.alu_op = alu_and;
                    fn_or:   payload.alu_op = alu_or;
                    fn_xor:  payload.alu_op = alu_xor;
                    fn_nor:  payload.alu_op = alu_nor;
                    fn_slt:  payload.alu_op = alu_slt;
                    fn_sltu: payload.alu_op = alu_sltu;
                    fn_sll, fn_srl, fn_sra: begin
                        payload.src_a = src_a_shamt;
                        payload.alu_op = (funct == fn_sll) ? alu_sll :
                                         (funct == fn_srl) ? alu_srl : alu_sra;
                    end
                    fn_jr: begin
                        payload.reg_write = 1'b0;
                        redirect          = valid;
                        redirect_pc       = rs_value;
                    end
                    default: payload.reg_write = 1'b0;
                endcase
            end
            op_addiu: payload.reg_write = 1'b1;
            op_slti: begin
                payload.reg_write = 1'b1;
                payload.alu_op    = alu_slt;
            end
            op_sltiu: begin
                payload.reg_write = 1'b1;
                payload.alu_op    = alu_sltu;
            end
            op_andi, op_ori, op_xori: begin
                payload.reg_write = 1'b1;
                payload.imm       = imm_zext;
                payload.alu_op    = (opcode == op_andi) ? alu_and :
                                    (opcode == op_ori) ? alu_or : alu_xor;
            end
            op_lui: begin
                payload.reg_write = 1'b1;
                payload.alu_op    = alu_lui;
            end
            op_beq: redirect = valid && (rs_value == rt_value);
            op_bne: redirect = valid && (rs_value != rt_value);
            op_j: begin
                redirect    = valid;
                redirect_pc = jump_target;
            end
            op_jal: begin
                redirect          = valid;
                redirect_pc       = jump_target;
                payload.reg_write = 1'b1;
                payload.dest      = reg_ra;
                payload.src_a     = src_a_pc;
                payload.src_b     = src_b_eight;
            end
            op_lb, op_lbu, op_lh, op_lhu, op_lw: begin
                payload.reg_write = 1'b1;
                payload.load      = 1'b1;
            end
            op_sb, op_sh, op_sw: payload.store = 1'b1;
            default: ;
        endcase
    end

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file import cpu_isa_pkg::*; (
    input  logic     clk,
    input  reg_num_t read_a,
    input  reg_num_t read_b,
    input  logic     write_en,
    input  reg_num_t write_num,
    input  word_t    write_data,
    output word_t    data_a,
    output word_t    data_b
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (write_en) begin
            regs[write_num] <= write_data;
        end
    end

    // r0 is hardwired, whatever was written to it
    assign data_a = (read_a == '0) ? '0 : regs[read_a];
    assign data_b = (read_b == '0) ? '0 : regs[read_b];

endmodule

/* source/forward_hazard.sv */
`timescale 1ns/1ps

module forward_hazard import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
    input  reg_num_t rs,
    input  reg_num_t rt,
    input  word_t    rf_rs,
    input  word_t    rf_rt,
    input  logic     ex_valid,
    input  id_ex_t   ex_payload,
    input  word_t    ex_result,
    input  logic     mem_valid,
    input  ex_mem_t  mem_payload,
    input  word_t    mem_data,
    input  logic     wb_valid,
    input  mem_wb_t  wb_payload,
    output word_t    rs_value,
    output word_t    rt_value,
    output logic     stall
);

    logic rs_ex;
    logic rs_mem;
    logic rs_wb;
    logic rt_ex;
    logic rt_mem;
    logic rt_wb;

    function automatic logic hit(logic valid, logic reg_write, reg_num_t dest, reg_num_t r);
        return valid && reg_write && (dest != '0) && (dest == r);
    endfunction

    assign rs_ex  = hit(ex_valid, ex_payload.reg_write, ex_payload.dest, rs);
    assign rs_mem = hit(mem_valid, mem_payload.reg_write, mem_payload.dest, rs);
    assign rs_wb  = hit(wb_valid, wb_payload.reg_write, wb_payload.dest, rs);
    assign rt_ex  = hit(ex_valid, ex_payload.reg_write, ex_payload.dest, rt);
    assign rt_mem = hit(mem_valid, mem_payload.reg_write, mem_payload.dest, rt);
    assign rt_wb  = hit(wb_valid, wb_payload.reg_write, wb_payload.dest, rt);

    // youngest producer first
    assign rs_value = rs_ex  ? ex_result :
                      rs_mem ? mem_data :
                      rs_wb  ? wb_payload.wdata : rf_rs;
    assign rt_value = rt_ex  ? ex_result :
                      rt_mem ? mem_data :
                      rt_wb  ? wb_payload.wdata : rf_rt;

    // load data is not ready until MEM
    assign stall = ex_payload.load && (rs_ex || rt_ex);

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
    input  id_ex_t     payload,
    input  logic       valid,
    output word_t      result,
    output ex_mem_t    out_payload,
    output logic       mem_en,
    output logic [3:0] mem_wen,
    output word_t      mem_addr,
    output word_t      mem_wdata
);

    word_t      a;
    word_t      b;
    logic [1:0] offset;
    logic [3:0] byte_en;

    always_comb begin
        case (payload.src_a)
            src_a_shamt: a = {27'd0, payload.shamt};
            src_a_pc:    a = payload.pc;
            default:     a = payload.rs_value;
        endcase
        case (payload.src_b)
            src_b_imm:   b = payload.imm;
            src_b_eight: b = 32'd8;
            default:     b = payload.rt_value;
        endcase
    end

    always_comb begin
        case (payload.alu_op)
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_nor:  result = ~(a | b);
            alu_slt:  result = {31'd0, $signed(a) < $signed(b)};
            alu_sltu: result = {31'd0, a < b};
            alu_sll:  result = b << a[4:0];
            alu_srl:  result = b >> a[4:0];
            alu_sra:  result = $signed(b) >>> a[4:0];
            alu_lui:  result = {b[15:0], 16'd0};
            default:  result = a + b;
        endcase
    end

    assign offset = result[1:0];

    // store data copied to every lane, enables pick the lane
    always_comb begin
        case (payload.mem_access)
            mem_byte, mem_byte_u: begin
                byte_en   = 4'b0001 << offset;
                mem_wdata = {4{payload.rt_value[7:0]}};
            end
            mem_half, mem_half_u: begin
                byte_en   = offset[1] ? 4'b1100 : 4'b0011;
                mem_wdata = {2{payload.rt_value[15:0]}};
            end
            default: begin
                byte_en   = 4'b1111;
                mem_wdata = payload.rt_value;
            end
        endcase
    end

    assign mem_en   = valid && (payload.load || payload.store);
    assign mem_wen  = (valid && payload.store) ? byte_en : 4'b0000;
    assign mem_addr = result;

    assign out_payload = '{
        pc:         payload.pc,
        result:     result,
        offset:     offset,
        mem_access: payload.mem_access,
        reg_write:  payload.reg_write,
        dest:       payload.dest,
        load:       payload.load
    };

endmodule

/* source/load_align.sv */
`timescale 1ns/1ps

module load_align import cpu_isa_pkg::*, cpu_pipe_pkg::*; (
    input  ex_mem_t payload,
    input  word_t   rdata,
    output mem_wb_t wb_payload
);

    word_t lane;
    word_t load_data;

    // addressed byte or half moved down to bit 0
    assign lane = rdata >> {payload.offset, 3'b000};

    always_comb begin
        case (payload.mem_access)
            mem_byte:   load_data = {{24{lane[7]}}, lane[7:0]};
            mem_byte_u: load_data = {24'd0, lane[7:0]};
            mem_half:   load_data = {{16{lane[15]}}, lane[15:0]};
            mem_half_u: load_data = {16'd0, lane[15:0]};
            default:    load_data = rdata;
        endcase
    end

    assign wb_payload = '{
        pc:        payload.pc,
        reg_write: payload.reg_write,
        dest:      payload.dest,
        wdata:     payload.load ? load_data : payload.result
    };

endmodule

/* source/mips_core_top.sv */
`timescale 1ns/1ps

module mips_core_top import cpu_isa_pkg::*, cpu_pipe_pkg::*; #(
    parameter word_t reset_pc = 32'hbfc00000
) (
    input  logic       clk,
    input  logic       reset,

    output logic       inst_sram_en,
    output logic [3:0] inst_sram_wen,
    output word_t      inst_sram_addr,
    output word_t      inst_sram_wdata,
    input  word_t      inst_sram_rdata,

    output logic       data_sram_en,
    output logic [3:0] data_sram_wen,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    input  word_t      data_sram_rdata,

    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_wen,
    output reg_num_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    logic        start;
    logic        redirect;
    word_t       redirect_pc;
    word_t       if_pc;
    logic        if_allow;
    logic        id_allow;
    logic        ex_allow;
    logic        mem_allow;

    logic [63:0] id_word;
    word_t       id_pc;
    word_t       id_instr;
    logic        id_valid;
    logic        id_valid_out;
    reg_num_t    rs;
    reg_num_t    rt;
    word_t       rf_rs;
    word_t       rf_rt;
    word_t       rs_value;
    word_t       rt_value;
    logic        stall;
    id_ex_t      id_payload;

    id_ex_t      ex_payload;
    logic        ex_valid;
    logic        ex_valid_out;
    word_t       ex_result;
    ex_mem_t     ex_out;

    ex_mem_t     mem_payload;
    logic        mem_valid;
    logic        mem_valid_out;
    mem_wb_t     mem_out;

    mem_wb_t     wb_payload;
    logic        wb_valid;
    logic        wb_valid_out;
    logic        wb_write;

    // instruction port is read only
    assign inst_sram_en    = 1'b1;
    assign inst_sram_wen   = 4'b0000;
    assign inst_sram_wdata = '0;

    fetch_unit #(.reset_pc(reset_pc)) i_fetch_unit (
        .clk         (clk),
        .reset       (reset),
        .allow_in    (if_allow),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (if_pc),
        .start       (start),
        .fetch_addr  (inst_sram_addr)
    );

    pipe_stage_reg #(.payload_t(logic [63:0])) if_id (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .valid_in  (start),
        .allow_out (id_allow),
        .in        ({if_pc, inst_sram_rdata}),
        .allow_in  (if_allow),
        .valid_out (id_valid_out),
        .valid     (id_valid),
        .out       (id_word)
    );

    assign id_pc    = id_word[63:32];
    assign id_instr = id_word[31:0];

    decode_control i_decode_control (
        .instr       (id_instr),
        .pc          (id_pc),
        .if_pc       (if_pc),
        .valid       (id_valid),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .rs          (rs),
        .rt          (rt),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .payload     (id_payload)
    );

    reg_file i_reg_file (
        .clk        (clk),
        .read_a     (rs),
        .read_b     (rt),
        .write_en   (wb_write),
        .write_num  (wb_payload.dest),
        .write_data (wb_payload.wdata),
        .data_a     (rf_rs),
        .data_b     (rf_rt)
    );

    forward_hazard i_forward_hazard (
        .rs          (rs),
        .rt          (rt),
        .rf_rs       (rf_rs),
        .rf_rt       (rf_rt),
        .ex_valid    (ex_valid),
        .ex_payload  (ex_payload),
        .ex_result   (ex_result),
        .mem_valid   (mem_valid),
        .mem_payload (mem_payload),
        .mem_data    (mem_out.wdata),
        .wb_valid    (wb_valid),
        .wb_payload  (wb_payload),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .stall       (stall)
    );

    pipe_stage_reg #(.payload_t(id_ex_t)) id_ex (
        .clk       (clk),
        .reset     (reset),
        .stall     (1'b0),
        .valid_in  (id_valid_out),
        .allow_out (ex_allow),
        .in        (id_payload),
        .allow_in  (id_allow),
        .valid_out (ex_valid_out),
        .valid     (ex_valid),
        .out       (ex_payload)
    );

    execute_stage i_execute_stage (
        .payload     (ex_payload),
        .valid       (ex_valid),
        .result      (ex_result),
        .out_payload (ex_out),
        .mem_en      (data_sram_en),
        .mem_wen     (data_sram_wen),
        .mem_addr    (data_sram_addr),
        .mem_wdata   (data_sram_wdata)
    );

    pipe_stage_reg #(.payload_t(ex_mem_t)) ex_mem (
        .clk       (clk),
        .reset     (reset),
        .stall     (1'b0),
        .valid_in  (ex_valid_out),
        .allow_out (mem_allow),
        .in        (ex_out),
        .allow_in  (ex_allow),
        .valid_out (mem_valid_out),
        .valid     (mem_valid),
        .out       (mem_payload)
    );

    load_align i_load_align (
        .payload    (mem_payload),
        .rdata      (data_sram_rdata),
        .wb_payload (mem_out)
    );

    pipe_stage_reg #(.payload_t(mem_wb_t)) mem_wb (
        .clk       (clk),
        .reset     (reset),
        .stall     (1'b0),
        .valid_in  (mem_valid_out),
        .allow_out (1'b1),
        .in        (mem_out),
        .allow_in  (mem_allow),
        .valid_out (wb_valid_out),
        .valid     (wb_valid),
        .out       (wb_payload)
    );

    assign wb_write = wb_valid_out && wb_payload.reg_write;

    assign debug_wb_pc       = wb_payload.pc;
    assign debug_wb_rf_wen   = {4{wb_write}};
    assign debug_wb_rf_wnum  = wb_payload.dest;
    assign debug_wb_rf_wdata = wb_payload.wdata;

endmodule

/* sim/mips_core_assertions.sv */
`timescale 1ns/1ps

module mips_core_assertions (
    input logic       clk,
    input logic       reset,
    input logic [3:0] debug_wb_rf_wen,
    input logic       data_sram_en,
    input logic [3:0] data_sram_wen
);

    int failures = 0;

    wen_bits_equal: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_wen == {4{debug_wb_rf_wen[0]}})
        else begin
            failures++;
            $error("debug_wb_rf_wen bits differ");
        end

    write_needs_enable: assert property (@(posedge clk) disable iff (reset)
        (data_sram_wen != 4'b0000) |-> data_sram_en)
        else begin
            failures++;
            $error("data_sram_wen set without data_sram_en");
        end

    // valid flags clear at the reset edge
    no_wb_in_reset: assert property (@(posedge clk)
        reset |=> (debug_wb_rf_wen == 4'b0000))
        else begin
            failures++;
            $error("writeback during reset");
        end

endmodule

bind mips_core_top mips_core_assertions i_mips_core_assertions (
    .clk             (clk),
    .reset           (reset),
    .debug_wb_rf_wen (debug_wb_rf_wen),
    .data_sram_en    (data_sram_en),
    .data_sram_wen   (data_sram_wen)
);

/* sim/tb_mips_core.sv */
`timescale 1ns/1ps

module tb_mips_core import cpu_isa_pkg::*; ();

    logic       clk;
    logic       reset;
    logic       inst_sram_en;
    logic [3:0] inst_sram_wen;
    word_t      inst_sram_addr;
    word_t      inst_sram_wdata;
    word_t      inst_sram_rdata;
    logic       data_sram_en;
    logic [3:0] data_sram_wen;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      data_sram_rdata;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_num_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t inst_mem [1024];
    word_t data_mem [1024];

    // expected writeback trace in program order
    word_t exp_pc [$];
    word_t exp_reg [$];
    word_t exp_data [$];

    int program_words;
    int cycle_limit;
    int cycle_count;
    int next_entry;

    mips_core_top #(.reset_pc(32'hbfc00000)) i_mips_core_top (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    task automatic load_cases();
        int         fd;
        int         n;
        string      line;
        logic [7:0] tag;
        word_t      a;
        word_t      b;
        word_t      c;
        fd = $fopen("sim/cpu_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the cases file sim/cpu_cases.txt");
            $display("SOME TESTS FAILED");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h", tag, a, b, c);
                if (tag == "P") begin
                    inst_mem[a[11:2]] = b;
                    program_words++;
                end else if (tag == "D") begin
                    data_mem[a[11:2]] = b;
                end else if (tag == "E") begin
                    exp_pc.push_back(a);
                    exp_reg.push_back(b);
                    exp_data.push_back(c);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "writeback trace differs");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        reset           = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        program_words   = 0;
        cycle_count     = 0;
        next_entry      = 0;
        // unused words run as nop, data words carry their own index
        for (int i = 0; i < 1024; i++) begin
            inst_mem[i] = '0;
            data_mem[i] = {16'hdada, 6'd0, i[9:0]};
        end
        load_cases();
        if (exp_pc.size() == 0) begin
            $display("the cases file holds no expected writeback entries");
            $display("SOME TESTS FAILED");
            $fatal(1, "empty trace");
        end
        cycle_limit = 20 * program_words + 100;
        repeat (4) @(posedge clk);
        #5 reset = 1'b0;
    end

    // both srams answer one cycle after the address
    always @(posedge clk) begin
        if (inst_sram_en) begin
            for (int k = 0; k < 4; k++) begin
                if (inst_sram_wen[k]) begin
                    inst_mem[inst_sram_addr[11:2]][8*k +: 8] <= inst_sram_wdata[8*k +: 8];
                end
            end
            inst_sram_rdata <= #5 inst_mem[inst_sram_addr[11:2]];
        end
        if (data_sram_en) begin
            for (int k = 0; k < 4; k++) begin
                if (data_sram_wen[k]) begin
                    data_mem[data_sram_addr[11:2]][8*k +: 8] <= data_sram_wdata[8*k +: 8];
                end
            end
            data_sram_rdata <= #5 data_mem[data_sram_addr[11:2]];
        end
    end

    // mid-cycle sampling of the writeback port
    always @(negedge clk) begin
        if (!reset) begin
            cycle_count++;
            if (i_mips_core_top.i_mips_core_assertions.failures != 0) begin
                $display("a protocol assertion on the core ports failed");
                $display("SOME TESTS FAILED");
                $fatal(1, "assertion failure");
            end
            // instruction port is never written
            check_value({28'd0, inst_sram_wen}, 32'd0, "inst_sram_wen");
            if (debug_wb_rf_wen[0] === 1'b1 && next_entry < exp_pc.size()) begin
                check_value(debug_wb_pc, exp_pc[next_entry],
                            $sformatf("pc of entry %0d", next_entry));
                check_value({27'd0, debug_wb_rf_wnum}, exp_reg[next_entry],
                            $sformatf("register of entry %0d", next_entry));
                check_value(debug_wb_rf_wdata, exp_data[next_entry],
                            $sformatf("data of entry %0d", next_entry));
                next_entry++;
            end
            if (next_entry == exp_pc.size()) begin
                $display("ALL TESTS PASSED");
                $finish;
            end else if (cycle_count > cycle_limit) begin
                $display("timeout: only %0d of %0d writebacks seen after %0d cycles",
                         next_entry, exp_pc.size(), cycle_count);
                $display("SOME TESTS FAILED");
                $fatal(1, "trace did not complete");
            end
        end
    end

endmodule

/* sim/cpu_cases.txt */
# P address word : program word, D address word : initial data word
# E pc register value : expected writeback, in program order
P bfc00000 3c011234
P bfc00004 34215678
P bfc00008 2402fffc
P bfc0000c 00221821
P bfc00010 00412023
P bfc00014 0041282a
P bfc00018 0041302b
P bfc0001c 00013900
P bfc00020 00024043
P bfc00024 00044a02
P bfc00028 00205027
P bfc0002c 382bffff
P bfc00030 304c8001
P bfc00034 284dffff
P bfc00038 2c0e0001
P bfc0003c 006b7826
P bfc00040 24140100
P bfc00044 ae810000
P bfc00048 a2840001
P bfc0004c a6820002
P bfc00050 8e950000
P bfc00054 02a0b021
P bfc00058 82970001
P bfc0005c 92980001
P bfc00060 86990002
P bfc00064 969a0000
P bfc00068 829b0007
P bfc0006c 8e910004
P bfc00070 16210002
P bfc00074 24120007
P bfc00078 24120063
P bfc0007c 12400005
P bfc00080 24130001
P bfc00084 0ff00028
P bfc00088 02728021
P bfc0008c 24000005
P bfc00090 241c0003
P bfc00094 0bf0002b
P bfc00098 379e0010
P bfc0009c 24120042
P bfc000a0 03e00008
P bfc000a4 241d0055
P bfc000a8 2412004d
P bfc000ac 03dd4821
P bfc000b0 1000ffff
P bfc000b4 00000000
D 00000100 deadbeef
D 00000104 80ff7f01
E bfc00000 01 12340000
E bfc00004 01 12345678
E bfc00008 02 fffffffc
E bfc0000c 03 12345674
E bfc00010 04 edcba984
E bfc00014 05 00000001
E bfc00018 06 00000000
E bfc0001c 07 23456780
E bfc00020 08 fffffffe
E bfc00024 09 00edcba9
E bfc00028 0a edcba987
E bfc0002c 0b 1234a987
E bfc00030 0c 00008000
E bfc00034 0d 00000001
E bfc00038 0e 00000001
E bfc0003c 0f 0000fff3
E bfc00040 14 00000100
E bfc00050 15 fffc8478
E bfc00054 16 fffc8478
E bfc00058 17 ffffff84
E bfc0005c 18 00000084
E bfc00060 19 fffffffc
E bfc00064 1a 00008478
E bfc00068 1b ffffff80
E bfc0006c 11 80ff7f01
E bfc00074 12 00000007
E bfc00080 13 00000001
E bfc00084 1f bfc0008c
E bfc00088 10 00000008
E bfc000a4 1d 00000055
E bfc0008c 00 00000005
E bfc00090 1c 00000003
E bfc00098 1e 00000013
E bfc000ac 09 00000068

/* src.f */
source/cpu_isa_pkg.sv
source/cpu_pipe_pkg.sv
source/pipe_stage_reg.sv
source/fetch_unit.sv
source/decode_control.sv
source/reg_file.sv
source/forward_hazard.sv
source/execute_stage.sv
source/load_align.sv
source/mips_core_top.sv
sim/mips_core_assertions.sv
sim/tb_mips_core.sv
